/* dv/clk_gen.sv */
// testbench clock and power-on reset generator
`timescale 1ns/100ps
`default_nettype none

module clk_gen #(
	parameter int PERIOD       = 10,
	parameter int RESET_CYCLES = 5
) (
	output logic CLK,
	output logic nRST
);

	initial begin
		CLK = 1'b0;
		forever begin
			#(PERIOD / 2) CLK = ~CLK;
		end
	end

	// release just after a rising edge
	initial begin
		nRST = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		#1 nRST = 1'b1;
	end

endmodule

`default_nettype wire

/* dv/mem_wb_back_end_tb.sv */
// back end testbench with random and directed stimulus, reference model, compare and watchdog
`timescale 1ns/100ps
`default_nettype none
`include "mem_wb_defines.svh"

module mem_wb_back_end_tb;

	import cpu_stage_pkg::*;

	localparam int CLK_PERIOD      = 10;
	localparam int RESET_CYCLES    = 5;
	localparam int NUM_OPS         = 2000;
	localparam int DIRECTED_CYCLES = 16;
	localparam int DRAIN_CYCLES    = 4;
	localparam int TOTAL_CYCLES    = RESET_CYCLES + `NUM_REGS + DIRECTED_CYCLES
		+ NUM_OPS + DRAIN_CYCLES + `NUM_REGS;
	localparam int WATCHDOG_NS     = TOTAL_CYCLES * CLK_PERIOD * 2;

	logic     CLK;
	logic     nRST;
	ex_mem_t  ex_in;
	logic     enable_ex_mem;
	logic     flush_ex_mem;
	logic     enable_mem_wb;
	logic     flush_mem_wb;
	regbits_t rsel;
	word_t    rdat;
	wb_port_t wb;
	logic     halt;

	// shadow pipeline, memory and registers
	ex_mem_t m_ex;
	mem_wb_t m_wb;
	word_t   m_mem [`DMEM_WORDS];
	word_t   m_regs [`NUM_REGS];

	int wb_errors;
	int halt_errors;
	int rdat_errors;
	int directed_errors;

	clk_gen #(
		.PERIOD       (CLK_PERIOD),
		.RESET_CYCLES (RESET_CYCLES)
	) u_clk_gen (
		.CLK  (CLK),
		.nRST (nRST)
	);

	mem_wb_back_end uut (
		.CLK           (CLK),
		.nRST          (nRST),
		.ex_in         (ex_in),
		.enable_ex_mem (enable_ex_mem),
		.flush_ex_mem  (flush_ex_mem),
		.enable_mem_wb (enable_mem_wb),
		.flush_mem_wb  (flush_mem_wb),
		.rsel          (rsel),
		.rdat          (rdat),
		.wb            (wb),
		.halt          (halt)
	);

	// expected write port for an op sitting in MEM/WB
	function automatic wb_port_t expected_wb(mem_wb_t s);
		wb_port_t w;
		case (s.reg_dest)
			SEL_RT:  w.wsel = s.rt;
			SEL_R31: w.wsel = 5'd31;
			default: w.wsel = s.rd;
		endcase
		if (s.reg_dest == SEL_R31) begin
			w.wdat = s.next_pc;
		end else if (s.mem_to_reg) begin
			w.wdat = s.load_data;
		end else begin
			w.wdat = s.result;
		end
		// r0 is never a real destination
		w.wen = s.wen && (w.wsel != 5'd0);
		return w;
	endfunction

	function automatic mem_wb_t to_mem_wb(ex_mem_t e, word_t ld);
		mem_wb_t s;
		s.wen        = e.wen;
		s.mem_to_reg = e.mem_to_reg;
		s.reg_dest   = e.reg_dest;
		s.rt         = e.rt;
		s.rd         = e.rd;
		s.result     = e.result;
		s.load_data  = ld;
		s.next_pc    = e.next_pc;
		s.halt       = e.halt;
		return s;
	endfunction

	// model advances on the same edge as the DUT
	always @(posedge CLK, negedge nRST) begin : model_step
		wb_port_t w;
		word_t    ld;
		if (!nRST) begin
			m_ex = '0;
			m_wb = '0;
			for (int i = 0; i < `DMEM_WORDS; i++) begin
				m_mem[i] = '0;
			end
			for (int i = 0; i < `NUM_REGS; i++) begin
				m_regs[i] = '0;
			end
		end else begin
			w = expected_wb(m_wb);
			if (w.wen) begin
				m_regs[w.wsel] = w.wdat;
			end
			ld = m_ex.dmemren ? m_mem[m_ex.result[`DMEM_ADDR_BITS+1:2]] : '0;
			if (m_ex.dmemwen) begin
				m_mem[m_ex.result[`DMEM_ADDR_BITS+1:2]] = m_ex.store_data;
			end
			if (flush_mem_wb) begin
				m_wb = '0;
			end else if (enable_mem_wb) begin
				m_wb = to_mem_wb(m_ex, ld);
			end
			if (flush_ex_mem) begin
				m_ex = '0;
			end else if (enable_ex_mem) begin
				m_ex = ex_in;
			end
		end
	end

	// compare on the falling edge away from input changes
	always @(negedge CLK) begin
		if (nRST) begin
			assert (wb === expected_wb(m_wb)) else begin
				wb_errors++;
				$display("error wb at %0t: expected %h, got %h", $time, expected_wb(m_wb), wb);
			end
			assert (halt === m_wb.halt) else begin
				halt_errors++;
				$display("error halt at %0t: expected %h, got %h", $time, m_wb.halt, halt);
			end
			assert (rdat === m_regs[rsel]) else begin
				rdat_errors++;
				$display("error rdat r%0d at %0t: expected %h, got %h",
					rsel, $time, m_regs[rsel], rdat);
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired, the test did not finish in time");
		$display("TEST FAIL");
		$finish;
	end

	task automatic next_cycle();
		@(posedge CLK);
		#1;
	endtask

	task automatic bubble_cycle();
		next_cycle();
		ex_in         = '0;
		enable_ex_mem = 1'b1;
		enable_mem_wb = 1'b1;
		flush_ex_mem  = 1'b0;
		flush_mem_wb  = 1'b0;
	endtask

	task automatic issue_op(input ex_mem_t op);
		bubble_cycle();
		ex_in = op;
	endtask

	task automatic check_register(input int idx, input word_t exp);
		next_cycle();
		rsel = regbits_t'(idx);
		@(negedge CLK);
		assert (rdat === exp) else begin
			directed_errors++;
			$display("error rdat r%0d: expected %h, got %h", idx, exp, rdat);
		end
	endtask

	function automatic word_t random_addr();
		word_t idx;
		idx = $urandom_range(0, `DMEM_WORDS - 1);
		return idx << 2;
	endfunction

	function automatic ex_mem_t random_op();
		ex_mem_t op;
		word_t   r;
		word_t   pc;
		int      kind;
		op            = '0;
		r             = $urandom;
		pc            = $urandom;
		kind          = $urandom_range(0, 3);
		op.rt         = r[4:0];
		op.rd         = r[9:5];
		op.halt       = (r[15:12] == 4'd0);
		op.result     = $urandom;
		op.store_data = $urandom;
		op.next_pc    = {pc[31:2], 2'b00};
		case (kind)
			0: begin
				op.wen      = 1'b1;
				op.reg_dest = r[16] ? SEL_RT : SEL_RD;
			end
			1: begin
				op.wen        = 1'b1;
				op.mem_to_reg = 1'b1;
				op.dmemren    = 1'b1;
				op.reg_dest   = SEL_RT;
				op.result     = random_addr();
			end
			2: begin
				op.dmemwen = 1'b1;
				op.result  = random_addr();
			end
			default: begin
				op.wen      = 1'b1;
				op.reg_dest = SEL_R31;
			end
		endcase
		return op;
	endfunction

	// a stall holds both stages so no op is duplicated
	task automatic random_cycle();
		logic stall;
		next_cycle();
		stall         = ($urandom_range(0, 9) == 0);
		ex_in         = random_op();
		enable_ex_mem = !stall;
		enable_mem_wb = !stall;
		flush_ex_mem  = ($urandom_range(0, 15) == 0);
		flush_mem_wb  = ($urandom_range(0, 15) == 0);
		rsel          = regbits_t'($urandom_range(0, 31));
	endtask

	initial begin
		ex_mem_t op;
		ex_in           = '0;
		enable_ex_mem   = 1'b0;
		flush_ex_mem    = 1'b0;
		enable_mem_wb   = 1'b0;
		flush_mem_wb    = 1'b0;
		rsel            = '0;
		wb_errors       = 0;
		halt_errors     = 0;
		rdat_errors     = 0;
		directed_errors = 0;
		void'($urandom(26));
		wait (nRST === 1'b1);

		// nothing written yet so every register reads zero
		for (int i = 0; i < `NUM_REGS; i++) begin
			check_register(i, '0);
		end

		// store then load the same word, load an untouched word, link with halt
		op            = '0;
		op.dmemwen    = 1'b1;
		op.result     = 32'h0000_0008;
		op.store_data = 32'hcafe_f00d;
		issue_op(op);
		op            = '0;
		op.wen        = 1'b1;
		op.mem_to_reg = 1'b1;
		op.dmemren    = 1'b1;
		op.reg_dest   = SEL_RT;
		op.rt         = 5'd5;
		op.result     = 32'h0000_0008;
		issue_op(op);
		op.rt         = 5'd6;
		op.result     = 32'h0000_00fc;
		issue_op(op);
		op            = '0;
		op.wen        = 1'b1;
		op.reg_dest   = SEL_R31;
		op.next_pc    = 32'h0000_0400;
		op.halt       = 1'b1;
		issue_op(op);
		repeat (3) bubble_cycle();
		check_register(5, 32'hcafe_f00d);
		check_register(6, '0);
		check_register(31, 32'h0000_0400);

		repeat (NUM_OPS) random_cycle();

		repeat (DRAIN_CYCLES) bubble_cycle();
		for (int i = 0; i < `NUM_REGS; i++) begin
			next_cycle();
			rsel = regbits_t'(i);
		end
		// let the last falling edge compare finish first
		@(negedge CLK);
		#1;

		$display("errors: wb %0d, halt %0d, rdat %0d, directed %0d",
			wb_errors, halt_errors, rdat_errors, directed_errors);
		if (wb_errors + halt_errors + rdat_errors + directed_errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* mem_wb_back_end.f */
+incdir+src
src/cpu_stage_pkg.sv
src/pipe_reg.sv
src/data_mem.sv
src/writeback.sv
src/register_file.sv
src/mem_wb_back_end.sv
dv/clk_gen.sv
dv/mem_wb_back_end_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the back end testbench with Verilator, then search the log for failures

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -j 0 \
	--top-module mem_wb_back_end_tb \
	-f mem_wb_back_end.f \
	-Mdir obj_dir > "$LOG" 2>&1 \
	&& ./obj_dir/Vmem_wb_back_end_tb >> "$LOG" 2>&1 \
	|| echo "TEST FAIL" >> "$LOG"

grep -q "TEST FAIL" "$LOG" \
	&& { echo "simulation failed, see $LOG"; exit 1; } \
	|| { echo "simulation passed"; exit 0; }

/* src/cpu_stage_pkg.sv */
// word, register index, destination select and pipeline stage payload types
`default_nettype none

package cpu_stage_pkg;

	// basic datapath widths
	typedef logic [31:0] word_t;
	typedef logic [4:0]  regbits_t;

	// destination register select
	// rd must stay zero so the all-zero bubble is a valid default
	typedef enum logic [1:0] {
		SEL_RD  = 2'd0,
		SEL_RT  = 2'd1,
		SEL_R31 = 2'd2
	} reg_dest_t;

	// EX/MEM payload
	typedef struct packed {
		logic      wen;
		logic      mem_to_reg;
		logic      dmemren;
		logic      dmemwen;
		reg_dest_t reg_dest;
		regbits_t  rt;
		regbits_t  rd;
		// alu result, also the byte address of a load or store
		word_t     result;
		word_t     store_data;
		word_t     next_pc;
		logic      halt;
	} ex_mem_t;

	// MEM/WB payload
	typedef struct packed {
		logic      wen;
		logic      mem_to_reg;
		reg_dest_t reg_dest;
		regbits_t  rt;
		regbits_t  rd;
		word_t     result;
		word_t     load_data;
		word_t     next_pc;
		logic      halt;
	} mem_wb_t;

	// register file write port, also exported for forwarding
	typedef struct packed {
		logic     wen;
		regbits_t wsel;
		word_t    wdat;
	} wb_port_t;

endpackage

`default_nettype wire

/* src/data_mem.sv */
// word-addressed data memory, combinational load and clocked store
`timescale 1ns/100ps
`default_nettype none
`include "mem_wb_defines.svh"

module data_mem (
	input  logic                CLK,
	input  logic                nRST,
	input  logic                ren,
	input  logic                wen,
	input  cpu_stage_pkg::word_t addr,
	input  cpu_stage_pkg::word_t store_data,
	output cpu_stage_pkg::word_t load_data
);

	import cpu_stage_pkg::*;

	word_t                      mem [`DMEM_WORDS];
	logic [`DMEM_ADDR_BITS-1:0] word_idx;

	// byte address down to word index
	assign word_idx = addr[`DMEM_ADDR_BITS+1:2];

	// zero when no load is active
	assign load_data = ren ? mem[word_idx] : '0;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < `DMEM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (wen) begin
			mem[word_idx] <= store_data;
		end
	end

	// decode upstream should never mark one op as both load and store
	a_no_rw_overlap: assert property (
		@(posedge CLK) disable iff (!nRST)
		!(ren && wen)
	);

	// alu result used as address must be aligned and in range
	a_addr_legal: assert property (
		@(posedge CLK) disable iff (!nRST)
		(ren || wen) |-> (addr[1:0] == 2'b00 && addr < (`DMEM_WORDS * 4))
	);

endmodule

`default_nettype wire

/* src/mem_wb_back_end.sv */
// back end top with EX/MEM and MEM/WB registers, data memory, writeback and register file
`timescale 1ns/100ps
`default_nettype none

module mem_wb_back_end (
	input  logic                    CLK,
	input  logic                    nRST,
	input  cpu_stage_pkg::ex_mem_t  ex_in,
	input  logic                    enable_ex_mem,
	input  logic                    flush_ex_mem,
	input  logic                    enable_mem_wb,
	input  logic                    flush_mem_wb,
	input  cpu_stage_pkg::regbits_t rsel,
	output cpu_stage_pkg::word_t    rdat,
	output cpu_stage_pkg::wb_port_t wb,
	output logic                    halt
);

	import cpu_stage_pkg::*;

	ex_mem_t ex_q;
	mem_wb_t wb_d;
	mem_wb_t wb_q;
	word_t   load_data;

	// EX/MEM register
	pipe_reg #(
		.payload_t(ex_mem_t)
	) u_ex_mem_reg (
		.CLK    (CLK),
		.nRST   (nRST),
		.enable (enable_ex_mem),
		.flush  (flush_ex_mem),
		.d      (ex_in),
		.q      (ex_q)
	);

	// memory access at the alu result address
	data_mem u_data_mem (
		.CLK        (CLK),
		.nRST       (nRST),
		.ren        (ex_q.dmemren),
		.wen        (ex_q.dmemwen),
		.addr       (ex_q.result),
		.store_data (ex_q.store_data),
		.load_data  (load_data)
	);

	// MEM/WB payload without the memory strobes and store data
	assign wb_d.wen        = ex_q.wen;
	assign wb_d.mem_to_reg = ex_q.mem_to_reg;
	assign wb_d.reg_dest   = ex_q.reg_dest;
	assign wb_d.rt         = ex_q.rt;
	assign wb_d.rd         = ex_q.rd;
	assign wb_d.result     = ex_q.result;
	assign wb_d.load_data  = load_data;
	assign wb_d.next_pc    = ex_q.next_pc;
	assign wb_d.halt       = ex_q.halt;

	// MEM/WB register
	pipe_reg #(
		.payload_t(mem_wb_t)
	) u_mem_wb_reg (
		.CLK    (CLK),
		.nRST   (nRST),
		.enable (enable_mem_wb),
		.flush  (flush_mem_wb),
		.d      (wb_d),
		.q      (wb_q)
	);

	writeback u_writeback (
		.stage (wb_q),
		.wb    (wb)
	);

	register_file u_register_file (
		.CLK  (CLK),
		.nRST (nRST),
		.wb   (wb),
		.rsel (rsel),
		.rdat (rdat)
	);

	// halt is seen as soon as the op reaches writeback
	assign halt = wb_q.halt;

endmodule

`default_nettype wire

/* src/mem_wb_defines.svh */
// data memory depth, word address width and register count macros
`ifndef MEM_WB_DEFINES_SVH
`define MEM_WB_DEFINES_SVH

// data memory size in 32-bit words
`define DMEM_WORDS 64

// word address bits, log2 of DMEM_WORDS
`define DMEM_ADDR_BITS 6

// architectural register count
`define NUM_REGS 32

`endif

/* src/pipe_reg.sv */
// generic pipeline stage register with enable and flush
`timescale 1ns/100ps
`default_nettype none

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     CLK,
	input  logic     nRST,
	input  logic     enable,
	input  logic     flush,
	input  payload_t d,
	output payload_t q
);

	payload_t q_nxt;

	// flush wins over enable, otherwise hold
	always_comb begin
		q_nxt = q;
		if (flush) begin
			q_nxt = '0;
		end else if (enable) begin
			q_nxt = d;
		end
	end

	// reset loads the bubble
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			q <= '0;
		end else begin
			q <= q_nxt;
		end
	end

	// upstream stage must never hand over X into a live pipeline
	a_q_known: assert property (
		@(posedge CLK) disable iff (!nRST)
		!$isunknown(q)
	);

endmodule

`default_nettype wire

/* src/register_file.sv */
// register file with r0 fixed at zero, one write port and one read port
`timescale 1ns/100ps
`default_nettype none
`include "mem_wb_defines.svh"

module register_file (
	input  logic                    CLK,
	input  logic                    nRST,
	input  cpu_stage_pkg::wb_port_t wb,
	input  cpu_stage_pkg::regbits_t rsel,
	output cpu_stage_pkg::word_t    rdat
);

	import cpu_stage_pkg::*;

	word_t regs [`NUM_REGS];

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.wen && (wb.wsel != '0)) begin
			regs[wb.wsel] <= wb.wdat;
		end
	end

	// r0 always reads zero
	assign rdat = (rsel == '0) ? '0 : regs[rsel];

	// writeback already masks r0, so a write strobe to r0 means a broken select path
	a_no_r0_write: assert property (
		@(posedge CLK) disable iff (!nRST)
		wb.wen |-> (wb.wsel != '0)
	);

endmodule

`default_nettype wire

/* src/writeback.sv */
// writeback data and destination selection from the MEM/WB payload
`timescale 1ns/100ps
`default_nettype none

module writeback (
	input  cpu_stage_pkg::mem_wb_t  stage,
	output cpu_stage_pkg::wb_port_t wb
);

	import cpu_stage_pkg::*;

	regbits_t wsel;
	word_t    wdat;

	// destination register
	always_comb begin
		case (stage.reg_dest)
			SEL_RT:  wsel = stage.rt;
			SEL_R31: wsel = 5'd31;
			default: wsel = stage.rd;
		endcase
	end

	// link address beats memory data beats alu result
	always_comb begin
		if (stage.reg_dest == SEL_R31) begin
			wdat = stage.next_pc;
		end else if (stage.mem_to_reg) begin
			wdat = stage.load_data;
		end else begin
			wdat = stage.result;
		end
	end

	// writes to r0 are dropped here so the forwarding port never shows them
	assign wb.wen  = stage.wen && (wsel != '0);
	assign wb.wsel = wsel;
	assign wb.wdat = wdat;

endmodule

`default_nettype wire
